// ==== Makefile ====
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -Wno-fatal
TOP       = lfb_entry_tb
FILELIST  = sim.f
OBJ_DIR   = obj_dir
LOG       = sim.log

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	-./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1
	cat $(LOG)
	grep -q "PASS: all tests" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== hw/lfb_bus_req.sv ====
/* bus read request fields */

`timescale 1ns/1ps

module lfb_bus_req
  import lfb_pkg::*;
(
  input  lfb_pa_u           pa,
  input  logic              ld,
  input  logic              pf,
  input  logic              ca,
  input  logic              so,
  input  logic              buf_en,
  input  logic [PRIV_W-1:0] priv_mode,
  input  logic [SIZE_W-1:0] size,
  input  lfb_state_t        state,
  output logic [PADDR-1:0]  ar_addr,
  output logic [1:0]        ar_len,
  output logic [2:0]        ar_size,
  output logic [3:0]        ar_cache,
  output logic [2:0]        ar_prot,
  output logic              ar_user,
  output logic              ld_wo_stall
);

  logic ld_inst;

  // ================================================
  // address and burst shape
  // ================================================
  // strongly ordered keeps the byte offset, others read whole quadwords
  assign ar_addr = {pa.cache.tag,
                    pa.cache.set,
                    pa.cache.qw_ofs,
                    so ? pa.cache.byte_ofs : {BYTE_W{1'b0}}};

  assign ar_len  = ca ? 2'b11 : 2'b00;
  assign ar_size = so ? {1'b0, size} : 3'b100;

  // ================================================
  // cache, protection and user bits
  // ================================================
  assign ar_cache = {ca, ca, !so, buf_en};
  assign ar_prot  = {1'b0, 1'b1, priv_mode[0]};
  assign ar_user  = priv_mode[1];

  // load can run on without stalling once the bus read is under way
  assign ld_inst     = ld && !pf;
  assign ld_wo_stall = ld_inst && !so && ((state == LFB_RBUS) || state[2]);

endmodule

// ==== hw/lfb_entry_regs.sv ====
/* fill buffer entry content */

`timescale 1ns/1ps

module lfb_entry_regs
  import lfb_pkg::*;
(
  input  logic              lfb_fsm_clk,
  input  logic              create_en,
  input  logic [PADDR-1:0]  create_pa,
  input  logic              create_ld,
  input  logic              create_pf,
  input  logic [ATTR_W-1:0] create_attr,
  input  logic              create_wb,
  input  logic [PRIV_W-1:0] create_priv_mode,
  input  logic [SIZE_W-1:0] create_size,
  input  logic [PREG_W-1:0] create_dest_reg,
  input  logic [VIDX_W-1:0] create_virt_idx,
  output lfb_pa_u           pa,
  output logic              ld,
  output logic              pf,
  output logic              ca,
  output logic              so,
  output logic              buf_en,
  output logic [PRIV_W-1:0] priv_mode,
  output logic [SIZE_W-1:0] size,
  output logic [PREG_W-1:0] dest_reg,
  output logic [VIDX_W-1:0] virt_idx
);

  logic [ATTR_W-1:0] attr_q;
  logic              wb_q;

  // ================================================
  // capture on create
  // ================================================
  always_ff @(posedge lfb_fsm_clk) begin
    if (create_en) begin
      pa        <= create_pa;
      ld        <= create_ld;
      pf        <= create_pf;
      attr_q    <= create_attr;
      wb_q      <= create_wb;
      priv_mode <= create_priv_mode;
      size      <= create_size;
      dest_reg  <= create_dest_reg;
      virt_idx  <= create_virt_idx;
    end
  end

  // attribute decode
  assign ca = attr_q[ATTR_CA];
  assign so = attr_q[ATTR_SO];

  // write-back hint only counts for cacheable lines
  assign buf_en = ca ? wb_q : attr_q[ATTR_BUF];

endmodule

// ==== hw/lfb_entry_top.sv ====
/* load fill buffer entry */

`timescale 1ns/1ps

module lfb_entry_top
  import lfb_pkg::*;
(
  input  logic lfb_fsm_clk, cpurst_b, create_en,
  input  logic [PADDR-1:0] create_pa,
  input  logic create_ld, create_pf,
  input  logic [ATTR_W-1:0] create_attr,
  input  logic create_wb,
  input  logic [PRIV_W-1:0] create_priv_mode,
  input  logic [SIZE_W-1:0] create_size,
  input  logic [PREG_W-1:0] create_dest_reg,
  input  logic [VIDX_W-1:0] create_virt_idx,
  input  logic rdl_grant, rdl_cmplt, rdl_cache_hit,
  input  logic bus_grant, bus_cmplt, bus_acc_err,
  input  logic [PADDR-1:0] dc_pa,
  input  logic [PREG_W-1:0] dc_dest_preg,
  output lfb_state_t state,
  output logic vld, rdl_req, arvalid, pop_en, bus_rdy,
  output logic hit_idx, hit_addr, hit_so, hit_preg,
  output logic [PADDR-1:0] ar_addr,
  output logic [1:0] ar_len,
  output logic [2:0] ar_size,
  output logic [3:0] ar_cache,
  output logic [2:0] ar_prot,
  output logic ar_user, ld_wo_stall, ref_en,
  output logic [1:0] ref_cnt,
  output logic [TAG_W-1:0] ref_tag,
  output logic [IDX_W-1:0] ref_idx,
  output logic [QW_W-1:0] ref_offset
);

  lfb_pa_u           pa;
  logic              ld, pf, ca, so, buf_en;
  logic [PRIV_W-1:0] priv_mode;
  logic [SIZE_W-1:0] size;
  logic [PREG_W-1:0] dest_reg;
  logic [VIDX_W-1:0] virt_idx;

  lfb_entry_regs u_regs (
    .lfb_fsm_clk, .create_en, .create_pa, .create_ld, .create_pf, .create_attr,
    .create_wb, .create_priv_mode, .create_size, .create_dest_reg, .create_virt_idx,
    .pa, .ld, .pf, .ca, .so, .buf_en, .priv_mode, .size, .dest_reg, .virt_idx
  );

  lfb_state_ctrl u_state_ctrl (
    .lfb_fsm_clk, .cpurst_b, .create_en, .rdl_grant, .rdl_cmplt, .rdl_cache_hit,
    .bus_grant, .bus_cmplt, .pf, .ca,
    .state, .vld, .rdl_req, .arvalid, .pop_en, .bus_rdy
  );

  lfb_hazard_check u_hazard (
    .vld, .pa, .ld, .pf, .dc_pa, .dc_dest_preg, .dest_reg, .so,
    .hit_idx, .hit_addr, .hit_so, .hit_preg
  );

  lfb_bus_req u_bus_req (
    .pa, .ld, .pf, .ca, .so, .buf_en, .priv_mode, .size, .state,
    .ar_addr, .ar_len, .ar_size, .ar_cache, .ar_prot, .ar_user, .ld_wo_stall
  );

  lfb_refill_req u_refill (
    .lfb_fsm_clk, .cpurst_b, .create_en, .bus_cmplt, .bus_acc_err, .ca, .pa,
    .virt_idx, .state, .ref_en, .ref_cnt, .ref_tag, .ref_idx, .ref_offset
  );

endmodule

// ==== hw/lfb_hazard_check.sv ====
/* data-cache stage hazard check */

`timescale 1ns/1ps

module lfb_hazard_check
  import lfb_pkg::*;
(
  input  logic              vld,
  input  lfb_pa_u           pa,
  input  logic              ld,
  input  logic              pf,
  input  logic [PADDR-1:0]  dc_pa,
  input  logic [PREG_W-1:0] dc_dest_preg,
  input  logic [PREG_W-1:0] dest_reg,
  input  logic              so,
  output logic              hit_idx,
  output logic              hit_addr,
  output logic              hit_so,
  output logic              hit_preg
);

  lfb_pa_u dc_u;

  assign dc_u = dc_pa;

  // set bits sit at the bottom of the line address
  assign hit_idx  = vld &&
                    (dc_u.line.line_addr[SET_W-1:0] == pa.line.line_addr[SET_W-1:0]);

  assign hit_addr = vld &&
                    (dc_u.line.line_addr[HAZ_MSB-LINE_OFS:0] ==
                     pa.line.line_addr[HAZ_MSB-LINE_OFS:0]);

  assign hit_so   = vld && ld && so;

  // prefetches write no register
  assign hit_preg = vld && ld && !pf && (dc_dest_preg == dest_reg);

endmodule

// ==== hw/lfb_pkg.sv ====
/* load fill buffer shared definitions */

package lfb_pkg;

  // ================================================
  // widths
  // ================================================
  localparam int PADDR    = 40;
  localparam int LINE_OFS = 6;
  localparam int QW_W     = 2;
  localparam int BYTE_W   = 4;
  localparam int SET_W    = 6;
  localparam int VIDX_W   = 2;
  localparam int IDX_W    = VIDX_W + SET_W;
  localparam int TAG_W    = 28;
  localparam int PREG_W   = 6;
  localparam int SIZE_W   = 2;
  localparam int PRIV_W   = 2;
  localparam int ATTR_W   = 3;

  // top address bit used by the line hazard compare
  localparam int HAZ_MSB  = 21;

  // attribute bit positions
  localparam int ATTR_CA  = 0;
  localparam int ATTR_SO  = 1;
  localparam int ATTR_BUF = 2;

  // ================================================
  // entry states
  // ================================================
  // bit 2 marks refill, bits 1:0 give the beat
  typedef enum logic [2:0] {
    LFB_IDLE  = 3'd0,
    LFB_WRDL  = 3'd1,
    LFB_RDL   = 3'd2,
    LFB_RBUS  = 3'd3,
    LFB_REF_1 = 3'd4,
    LFB_REF_2 = 3'd5,
    LFB_REF_3 = 3'd6,
    LFB_REF_4 = 3'd7
  } lfb_state_t;

  // ================================================
  // physical address, two decodings
  // ================================================
  typedef union packed {
    struct packed {
      logic [PADDR-LINE_OFS-1:0] line_addr;
      logic [LINE_OFS-1:0]       line_ofs;
    } line;
    struct packed {
      logic [TAG_W-1:0]  tag;
      logic [SET_W-1:0]  set;
      logic [QW_W-1:0]   qw_ofs;
      logic [BYTE_W-1:0] byte_ofs;
    } cache;
  } lfb_pa_u;

endpackage

// ==== hw/lfb_refill_req.sv ====
/* refill request fields */

`timescale 1ns/1ps

module lfb_refill_req
  import lfb_pkg::*;
(
  input  logic              lfb_fsm_clk,
  input  logic              cpurst_b,
  input  logic              create_en,
  input  logic              bus_cmplt,
  input  logic              bus_acc_err,
  input  logic              ca,
  input  lfb_pa_u           pa,
  input  logic [VIDX_W-1:0] virt_idx,
  input  lfb_state_t        state,
  output logic              ref_en,
  output logic [1:0]        ref_cnt,
  output logic [TAG_W-1:0]  ref_tag,
  output logic [IDX_W-1:0]  ref_idx,
  output logic [QW_W-1:0]   ref_offset
);

  logic ref_err;

  // sticky until the next entry is created
  always_ff @(posedge lfb_fsm_clk or negedge cpurst_b) begin
    if (!cpurst_b) begin
      ref_err <= 1'b0;
    end else if (create_en) begin
      ref_err <= 1'b0;
    end else if (bus_cmplt && bus_acc_err) begin
      ref_err <= 1'b1;
    end
  end

  // refill only while the entry holds a line
  assign ref_en     = ca && !ref_err && (state != LFB_IDLE);
  assign ref_cnt    = state[1:0];
  assign ref_tag    = pa.cache.tag;
  assign ref_idx    = {virt_idx, pa.cache.set};
  assign ref_offset = pa.cache.qw_ofs;

endmodule

// ==== hw/lfb_state_ctrl.sv ====
/* fill buffer entry state machine */

`timescale 1ns/1ps

module lfb_state_ctrl
  import lfb_pkg::*;
(
  input  logic       lfb_fsm_clk,
  input  logic       cpurst_b,
  input  logic       create_en,
  input  logic       rdl_grant,
  input  logic       rdl_cmplt,
  input  logic       rdl_cache_hit,
  input  logic       bus_grant,
  input  logic       bus_cmplt,
  input  logic       pf,
  input  logic       ca,
  output lfb_state_t state,
  output logic       vld,
  output logic       rdl_req,
  output logic       arvalid,
  output logic       pop_en,
  output logic       bus_rdy
);

  lfb_state_t next_state;
  logic       pf_hit_done;
  logic       refill_last;

  // ================================================
  // state register
  // ================================================
  always_ff @(posedge lfb_fsm_clk or negedge cpurst_b) begin
    if (!cpurst_b) begin
      state <= LFB_IDLE;
    end else begin
      state <= next_state;
    end
  end

  always_comb begin
    next_state = state;
    case (state)
      LFB_IDLE: begin
        if (create_en) next_state = LFB_WRDL;
      end
      LFB_WRDL: begin
        if (rdl_grant) next_state = LFB_RDL;
      end
      LFB_RDL: begin
        // prefetch already in the cache needs no bus read
        if (rdl_cmplt) next_state = (pf && rdl_cache_hit) ? LFB_IDLE : LFB_RBUS;
      end
      LFB_RBUS: begin
        if (bus_grant) next_state = LFB_REF_1;
      end
      LFB_REF_1: begin
        if (bus_cmplt) next_state = ca ? LFB_REF_2 : LFB_IDLE;
      end
      LFB_REF_2: begin
        if (bus_cmplt) next_state = LFB_REF_3;
      end
      LFB_REF_3: begin
        if (bus_cmplt) next_state = LFB_REF_4;
      end
      LFB_REF_4: begin
        if (bus_cmplt) next_state = LFB_IDLE;
      end
      default: next_state = LFB_IDLE;
    endcase
  end

  // ================================================
  // strobes
  // ================================================
  assign vld     = (state != LFB_IDLE);
  assign rdl_req = (state == LFB_WRDL);
  assign arvalid = (state == LFB_RBUS);

  assign pf_hit_done = (state == LFB_RDL) && rdl_cmplt && pf && rdl_cache_hit;

  // single beat for non-cacheable, fourth beat otherwise
  assign refill_last = bus_cmplt &&
                       (((state == LFB_REF_1) && !ca) || (state == LFB_REF_4));

  assign pop_en  = pf_hit_done || refill_last;
  assign bus_rdy = pf_hit_done || ((state == LFB_RBUS) && bus_grant);

endmodule

// ==== sim.f ====
hw/lfb_pkg.sv
hw/lfb_entry_regs.sv
hw/lfb_state_ctrl.sv
hw/lfb_hazard_check.sv
hw/lfb_bus_req.sv
hw/lfb_refill_req.sv
hw/lfb_entry_top.sv
test/lfb_entry_sva.sv
test/lfb_entry_tb.sv

// ==== test/lfb_entry_sva.sv ====
/* entry state machine assertions */

`timescale 1ns/1ps

module lfb_entry_sva
  import lfb_pkg::*;
(
  input logic       lfb_fsm_clk,
  input logic       cpurst_b,
  input lfb_state_t state,
  input logic       rdl_req,
  input logic       rdl_grant,
  input logic       arvalid,
  input logic       pop_en,
  input logic       bus_grant
);

  int unsigned fail_cnt = 0;

  // read-line request stays up until granted
  a_rdl_req_hold: assert property (@(posedge lfb_fsm_clk) disable iff (!cpurst_b)
    (rdl_req && !rdl_grant) |=> rdl_req)
  else begin
    fail_cnt++;
    $error("rdl_req dropped before rdl_grant");
  end

  // entry is free right after it pops
  a_pop_idle: assert property (@(posedge lfb_fsm_clk) disable iff (!cpurst_b)
    pop_en |=> (state == LFB_IDLE))
  else begin
    fail_cnt++;
    $error("entry not idle after pop_en");
  end

  a_arvalid_hold: assert property (@(posedge lfb_fsm_clk) disable iff (!cpurst_b)
    (arvalid && !bus_grant) |=> arvalid)
  else begin
    fail_cnt++;
    $error("arvalid dropped before bus_grant");
  end

endmodule

bind lfb_state_ctrl lfb_entry_sva u_sva (
  .lfb_fsm_clk, .cpurst_b, .state, .rdl_req, .rdl_grant, .arvalid, .pop_en, .bus_grant
);

// ==== test/lfb_entry_tb.sv ====
/* load fill buffer entry testbench */

`timescale 1ns/1ps

module lfb_entry_tb
  import lfb_pkg::*;
();

  localparam int NUM_ROWS = 7;
  localparam int CLK_HALF = 4;

  typedef struct packed {
    logic [PADDR-1:0]  pa;
    logic              ld;
    logic              pf;
    logic [ATTR_W-1:0] attr;
    logic              wb;
    logic [PRIV_W-1:0] priv;
    logic [SIZE_W-1:0] size;
    logic [PREG_W-1:0] dest;
    logic              hit;
    logic [2:0]        err_beat;
    logic [1:0]        exp_len;
    logic [2:0]        exp_size;
    logic [3:0]        exp_cache;
    logic [3:0]        exp_ofs;
    logic [2:0]        exp_beats;
    logic              exp_ref_en;
  } row_t;

  logic lfb_fsm_clk, cpurst_b, create_en, create_ld, create_pf, create_wb;
  logic [PADDR-1:0] create_pa, dc_pa, ar_addr;
  logic [ATTR_W-1:0] create_attr;
  logic [PRIV_W-1:0] create_priv_mode;
  logic [SIZE_W-1:0] create_size;
  logic [PREG_W-1:0] create_dest_reg, dc_dest_preg;
  logic [VIDX_W-1:0] create_virt_idx;
  logic rdl_grant, rdl_cmplt, rdl_cache_hit, bus_grant, bus_cmplt, bus_acc_err;
  lfb_state_t state;
  logic vld, rdl_req, arvalid, pop_en, bus_rdy, hit_idx, hit_addr, hit_so, hit_preg;
  logic [1:0] ar_len, ref_cnt;
  logic [2:0] ar_size, ar_prot;
  logic [3:0] ar_cache;
  logic ar_user, ld_wo_stall, ref_en;
  logic [TAG_W-1:0] ref_tag;
  logic [IDX_W-1:0] ref_idx;
  logic [QW_W-1:0] ref_offset;

  row_t        rows [NUM_ROWS];
  int unsigned rnd_seed;

  lfb_entry_top UUT (.*);

  initial lfb_fsm_clk = 1'b0;
  always #CLK_HALF lfb_fsm_clk = ~lfb_fsm_clk;

  // ================================================
  // helpers
  // ================================================
  task automatic abort_run();
    $display("FAIL: see errors above");
    $fatal(1);
  endtask

  task automatic check_eq(input logic [63:0] actual, input logic [63:0] expected,
                          input string msg);
    if (actual !== expected) begin
      $display("MISMATCH at time %0t: %s (got %0h, expected %0h)",
               $time, msg, actual, expected);
      abort_run();
    end
  endtask

  // drive point, just after the rising edge
  task automatic tick();
    @(posedge lfb_fsm_clk);
    #1;
  endtask

  // pa, ld, pf, attr, wb, priv, size, dest, hit, err_beat,
  // then expected len, size, cache, offset, beats, ref_en at pop
  task automatic fill_table();
    rows[0] = '{40'h00_1234_5678, 1'b1, 1'b0, 3'b001, 1'b1, 2'b11, 2'b10, 6'd17,
                1'b0, 3'd0, 2'd3, 3'd4, 4'hF, 4'h0, 3'd4, 1'b1};
    rows[1] = '{40'h80_0000_0F0B, 1'b1, 1'b0, 3'b010, 1'b1, 2'b01, 2'b01, 6'd5,
                1'b0, 3'd0, 2'd0, 3'd1, 4'h0, 4'hB, 3'd1, 1'b0};
    rows[2] = '{40'h00_2000_1040, 1'b1, 1'b1, 3'b001, 1'b0, 2'b00, 2'b11, 6'd9,
                1'b1, 3'd0, 2'd3, 3'd4, 4'hE, 4'h0, 3'd0, 1'b1};
    rows[3] = '{40'h01_0ABC_D3C8, 1'b1, 1'b0, 3'b101, 1'b0, 2'b10, 2'b11, 6'd33,
                1'b0, 3'd2, 2'd3, 3'd4, 4'hE, 4'h0, 3'd4, 1'b0};
    rows[4] = '{40'h01_0ABC_D3C0, 1'b1, 1'b0, 3'b001, 1'b0, 2'b00, 2'b10, 6'd40,
                1'b0, 3'd0, 2'd3, 3'd4, 4'hE, 4'h0, 3'd4, 1'b1};
    rows[5] = '{40'h00_0FFF_FFC4, 1'b1, 1'b1, 3'b001, 1'b1, 2'b01, 2'b00, 6'd63,
                1'b0, 3'd4, 2'd3, 3'd4, 4'hF, 4'h0, 3'd4, 1'b1};
    rows[6] = '{40'h7F_0000_0207, 1'b1, 1'b0, 3'b100, 1'b0, 2'b10, 2'b00, 6'd2,
                1'b0, 3'd0, 2'd0, 3'd4, 4'h3, 4'h0, 3'd1, 1'b0};
  endtask

  // ================================================
  // one entry from create to pop
  // ================================================
  task automatic run_row(input int r);
    row_t row;
    logic exp_ref;
    row = rows[r];
    tick();
    create_en        = 1'b1;
    create_pa        = row.pa;
    create_ld        = row.ld;
    create_pf        = row.pf;
    create_attr      = row.attr;
    create_wb        = row.wb;
    create_priv_mode = row.priv;
    create_size      = row.size;
    create_dest_reg  = row.dest;
    create_virt_idx  = r[1:0];
    dc_pa            = row.pa;
    dc_dest_preg     = row.dest;
    @(negedge lfb_fsm_clk);
    check_eq(vld, 1'b0, "vld before create");
    tick();
    create_en = 1'b0;
    @(negedge lfb_fsm_clk);
    check_eq(rdl_req, 1'b1, "rdl_req after create");
    check_eq(hit_idx, 1'b1, "hit_idx on matching set");
    check_eq(hit_addr, 1'b1, "hit_addr on matching line");
    check_eq(hit_so, row.ld && row.attr[ATTR_SO], "hit_so");
    check_eq(hit_preg, row.ld && !row.pf, "hit_preg on matching register");
    check_eq(ld_wo_stall, 1'b0, "ld_wo_stall before bus request");
    tick();
    repeat ($urandom % 4) begin
      @(negedge lfb_fsm_clk);
      check_eq(rdl_req, 1'b1, "rdl_req held without grant");
      tick();
    end
    rdl_grant    = 1'b1;
    dc_pa        = row.pa ^ 40'h00_003F_FFC0;
    dc_dest_preg = ~row.dest;
    @(negedge lfb_fsm_clk);
    check_eq(hit_idx, 1'b0, "hit_idx on differing set");
    check_eq(hit_addr, 1'b0, "hit_addr on differing line");
    check_eq(hit_preg, 1'b0, "hit_preg on differing register");
    tick();
    rdl_grant    = 1'b0;
    dc_pa        = row.pa;
    dc_dest_preg = row.dest;
    repeat ($urandom % 4) begin
      @(negedge lfb_fsm_clk);
      check_eq(state, LFB_RDL, "read-line state held without complete");
      tick();
    end
    rdl_cmplt     = 1'b1;
    rdl_cache_hit = row.hit;
    @(negedge lfb_fsm_clk);
    check_eq(pop_en, row.exp_beats == 0, "pop_en at read-line complete");
    check_eq(bus_rdy, row.exp_beats == 0, "bus_rdy at read-line complete");
    check_eq(arvalid, 1'b0, "arvalid during read-line");
    if (row.exp_beats == 0) check_eq(ref_en, row.exp_ref_en, "ref_en at pop");
    tick();
    rdl_cmplt     = 1'b0;
    rdl_cache_hit = 1'b0;
    if (row.exp_beats != 0) begin
      @(negedge lfb_fsm_clk);
      check_eq(arvalid, 1'b1, "arvalid in bus request state");
      check_eq(ar_len, row.exp_len, "ar_len");
      check_eq(ar_size, row.exp_size, "ar_size");
      check_eq(ar_cache, row.exp_cache, "ar_cache");
      check_eq(ar_addr[3:0], row.exp_ofs, "ar_addr offset");
      check_eq(ar_addr[PADDR-1:4], row.pa[PADDR-1:4], "ar_addr line part");
      check_eq(ar_prot, {2'b01, row.priv[0]}, "ar_prot");
      check_eq(ar_user, row.priv[1], "ar_user");
      check_eq(ld_wo_stall, row.ld && !row.pf && !row.attr[ATTR_SO], "ld_wo_stall");
      check_eq(ref_tag, row.pa[PADDR-1:12], "ref_tag");
      check_eq(ref_idx, {r[1:0], row.pa[11:6]}, "ref_idx");
      check_eq(ref_offset, row.pa[5:4], "ref_offset");
      tick();
      repeat ($urandom % 4) begin
        @(negedge lfb_fsm_clk);
        check_eq(arvalid, 1'b1, "arvalid held without grant");
        tick();
      end
      bus_grant = 1'b1;
      @(negedge lfb_fsm_clk);
      check_eq(bus_rdy, 1'b1, "bus_rdy at bus grant");
      tick();
      bus_grant = 1'b0;
      for (int b = 1; b <= row.exp_beats; b++) begin
        repeat ($urandom % 4) begin
          @(negedge lfb_fsm_clk);
          check_eq(ref_cnt, b - 1, "ref_cnt held between beats");
          tick();
        end
        bus_cmplt   = 1'b1;
        bus_acc_err = (row.err_beat == b);
        // error shows one cycle after the beat that carried it
        exp_ref = (b == row.exp_beats) ? row.exp_ref_en :
                  (row.attr[ATTR_CA] && !(row.err_beat != 0 && row.err_beat < b));
        @(negedge lfb_fsm_clk);
        check_eq(ref_cnt, b - 1, "ref_cnt at bus complete");
        check_eq(pop_en, b == row.exp_beats, "pop_en at bus complete");
        check_eq(ref_en, exp_ref, "ref_en at bus complete");
        tick();
        bus_cmplt   = 1'b0;
        bus_acc_err = 1'b0;
      end
    end
    @(negedge lfb_fsm_clk);
    check_eq(vld, 1'b0, "vld after pop");
    check_eq(pop_en, 1'b0, "pop_en after pop");
    check_eq(arvalid, 1'b0, "arvalid after pop");
    check_eq({hit_idx, hit_addr, hit_so, hit_preg}, 4'b0, "hit outputs after pop");
  endtask

  // ================================================
  // main sequence and watchdog
  // ================================================
  initial begin
    #((NUM_ROWS * 40 + 10) * 2 * CLK_HALF);
    $display("ERROR: watchdog timeout, the entry stopped responding");
    abort_run();
  end

  initial begin
    rnd_seed = $urandom(32'ha034);
    {create_en, create_ld, create_pf, create_wb} = '0;
    {create_pa, create_attr, create_priv_mode, create_size} = '0;
    {create_dest_reg, create_virt_idx, dc_pa, dc_dest_preg} = '0;
    {rdl_grant, rdl_cmplt, rdl_cache_hit, bus_grant, bus_cmplt, bus_acc_err} = '0;
    cpurst_b = 1'b0;
    fill_table();
    repeat (5) @(posedge lfb_fsm_clk);
    #1;
    cpurst_b = 1'b1;
    @(negedge lfb_fsm_clk);
    check_eq({vld, rdl_req, arvalid, pop_en, bus_rdy, ref_en}, 6'b0, "outputs after reset");
    for (int r = 0; r < NUM_ROWS; r++) begin
      run_row(r);
    end
    if (UUT.u_state_ctrl.u_sva.fail_cnt == 0) begin
      $display("PASS: all tests");
      $finish;
    end else begin
      $display("ERROR: state machine assertions failed");
      abort_run();
    end
  end

endmodule
